/* include/mopshub_macros.svh */
`ifndef MOPSHUB_MACROS_SVH
`define MOPSHUB_MACROS_SVH

// Hub size
`define N_BUSES 4
`define BUS_ID_W 2

// clk_40 cycles per bit on a front-end bus
`define MOPS_BIT_CYCLES 4

// Node frame fields
`define NODE_ID_W 8
`define PAYLOAD_W 16

// Serial e-link word
`define ELINK_W 32

`endif

/* src/mopshub_pkg.sv */
`include "mopshub_macros.svh"

package mopshub_pkg;

  // Kind bit of an uplink word
  localparam logic KIND_DATA   = 1'b0;
  localparam logic KIND_STATUS = 1'b1;

  // One uplink word, read as node data or as channel status
  typedef union packed {
    struct packed {
      logic                  kind;
      logic [`BUS_ID_W-1:0]  bus_id;
      logic [`NODE_ID_W-1:0] node_id;
      logic [`PAYLOAD_W-1:0] payload;
      logic [`ELINK_W-1-`BUS_ID_W-`NODE_ID_W-`PAYLOAD_W-1:0] zero;
    } data;
    struct packed {
      logic                  kind;
      logic [`BUS_ID_W-1:0]  bus_id;
      logic [7:0]            err_cnt;
      logic [`ELINK_W-1-`BUS_ID_W-8-1:0] zero;
    } status;
  } hub_word_u;

endpackage

/* src/bus_channel.sv */
`include "mopshub_macros.svh"

module bus_channel #(
  parameter int CH_ID = 0
) (
  input  logic                   clk_40,
  input  logic                   rst,
  input  logic                   rx,
  input  logic                   grant,
  input  logic                   dn_valid,
  input  logic [`BUS_ID_W-1:0]   dn_bus,
  input  logic [`NODE_ID_W-1:0]  dn_node,
  input  logic [`PAYLOAD_W-1:0]  dn_payload,
  output logic                   tx,
  output logic                   up_req,
  output mopshub_pkg::hub_word_u up_word
);

  // Id, payload and parity sit between start and stop
  localparam int SH_W       = `NODE_ID_W + `PAYLOAD_W + 1;
  localparam int FRAME_BITS = SH_W + 2;
  localparam int CYC_W      = $clog2(`MOPS_BIT_CYCLES);
  localparam int BIT_W      = $clog2(FRAME_BITS);
  // Falling edge is seen one clock into the start bit
  localparam int HALF_WAIT  = `MOPS_BIT_CYCLES / 2 - 2;

  logic                         rx_active;
  logic [CYC_W-1:0]             rx_cyc;
  logic [BIT_W-1:0]             rx_bit;
  logic [SH_W-1:0]              rx_sh;
  logic                         stop_sample;
  logic                         frame_good;
  logic                         pending;
  logic                         drain_status;
  logic [7:0]                   err_cnt;
  logic [7:0]                   err_next;
  logic                         miss;
  mopshub_pkg::hub_word_u       data_word;
  mopshub_pkg::hub_word_u       status_word;

  logic                         tx_active;
  logic [CYC_W-1:0]             tx_cyc;
  logic [BIT_W-1:0]             tx_bit;
  logic [FRAME_BITS-2:0]        tx_sh;
  logic                         dn_hit;

  // Receive deserializer, samples at bit centres
  always_ff @(posedge clk_40)
  begin
    if (!rst)
    begin
      rx_active <= 1'b0;
      rx_cyc    <= '0;
      rx_bit    <= '0;
    end
    else if (!rx_active)
    begin
      if (!rx)
      begin
        rx_active <= 1'b1;
        rx_cyc    <= CYC_W'(HALF_WAIT);
        rx_bit    <= '0;
      end
    end
    else if (rx_cyc != '0)
      rx_cyc <= rx_cyc - 1'b1;
    else
    begin
      rx_cyc <= CYC_W'(`MOPS_BIT_CYCLES - 1);
      rx_bit <= rx_bit + 1'b1;
      // Glitch on the line, not a real start bit
      if (rx_bit == '0 && rx)
        rx_active <= 1'b0;
      else if (rx_bit == BIT_W'(FRAME_BITS - 1))
        rx_active <= 1'b0;
    end
  end

  always_ff @(posedge clk_40)
  begin
    if (rx_active && rx_cyc == '0 && rx_bit != '0 && rx_bit != BIT_W'(FRAME_BITS - 1))
      rx_sh <= {rx, rx_sh[SH_W-1:1]};
  end

  assign stop_sample = rx_active && rx_cyc == '0 && rx_bit == BIT_W'(FRAME_BITS - 1);
  // Good stop bit and even parity over id, payload and parity bit
  assign frame_good  = rx && !(^rx_sh);
  assign pending     = up_req && !grant;
  assign drain_status = !stop_sample && !grant && miss && !up_req;
  assign err_next    = (err_cnt == 8'hff) ? err_cnt : err_cnt + 8'd1;

  always_comb
  begin
    data_word              = '0;
    data_word.data.kind    = mopshub_pkg::KIND_DATA;
    data_word.data.bus_id  = `BUS_ID_W'(CH_ID);
    data_word.data.node_id = rx_sh[`NODE_ID_W-1:0];
    data_word.data.payload = rx_sh[`NODE_ID_W +: `PAYLOAD_W];
  end

  always_comb
  begin
    status_word                = '0;
    status_word.status.kind    = mopshub_pkg::KIND_STATUS;
    status_word.status.bus_id  = `BUS_ID_W'(CH_ID);
    status_word.status.err_cnt = stop_sample ? err_next : err_cnt;
  end

  // Pending uplink word and error bookkeeping
  always_ff @(posedge clk_40)
  begin
    if (!rst)
    begin
      up_req  <= 1'b0;
      err_cnt <= '0;
      miss    <= 1'b0;
    end
    else if (stop_sample && pending)
    begin
      // No room, the frame is lost
      err_cnt <= err_next;
      miss    <= 1'b1;
    end
    else if (stop_sample)
    begin
      up_req <= 1'b1;
      if (!frame_good)
      begin
        err_cnt <= err_next;
        miss    <= 1'b0;
      end
    end
    else if (grant)
      up_req <= 1'b0;
    else if (drain_status)
    begin
      up_req <= 1'b1;
      miss   <= 1'b0;
    end
  end

  always_ff @(posedge clk_40)
  begin
    if (stop_sample && !pending)
      up_word <= frame_good ? data_word : status_word;
    else if (drain_status)
      up_word <= status_word;
  end

  // Transmit serializer for downlink commands
  assign dn_hit = dn_valid && dn_bus == `BUS_ID_W'(CH_ID) && !tx_active;

  always_ff @(posedge clk_40)
  begin
    if (!rst)
    begin
      tx        <= 1'b1;
      tx_active <= 1'b0;
      tx_cyc    <= '0;
      tx_bit    <= '0;
    end
    else if (dn_hit)
    begin
      tx        <= 1'b0;
      tx_active <= 1'b1;
      tx_cyc    <= CYC_W'(`MOPS_BIT_CYCLES - 1);
      tx_bit    <= BIT_W'(FRAME_BITS - 1);
    end
    else if (tx_active)
    begin
      if (tx_cyc != '0)
        tx_cyc <= tx_cyc - 1'b1;
      else
      begin
        tx_cyc <= CYC_W'(`MOPS_BIT_CYCLES - 1);
        if (tx_bit == '0)
          tx_active <= 1'b0;
        else
        begin
          tx     <= tx_sh[0];
          tx_bit <= tx_bit - 1'b1;
        end
      end
    end
  end

  // Stop, parity, payload, node id; sent from bit 0 up
  always_ff @(posedge clk_40)
  begin
    if (dn_hit)
      tx_sh <= {1'b1, ^{dn_node, dn_payload}, dn_payload, dn_node};
    else if (tx_active && tx_cyc == '0)
      tx_sh <= tx_sh >> 1;
  end

endmodule

/* src/uplink_arbiter.sv */
`include "mopshub_macros.svh"

module uplink_arbiter (
  input  logic                                 clk_40,
  input  logic                                 rst,
  input  logic [`N_BUSES-1:0]                  up_req,
  input  mopshub_pkg::hub_word_u [`N_BUSES-1:0] up_word,
  input  logic                                 busy,
  output logic [`N_BUSES-1:0]                  grant,
  output logic                                 load,
  output mopshub_pkg::hub_word_u               load_word
);

  logic [`BUS_ID_W-1:0] ptr;
  logic [`BUS_ID_W-1:0] win;
  logic                 found;
  int                   idx;

  // First requester at or after the pointer
  always_comb
  begin
    found = 1'b0;
    win   = '0;
    idx   = 0;
    for (int k = 0; k < `N_BUSES; k++)
    begin
      idx = (int'(ptr) + k) % `N_BUSES;
      if (!found && up_req[idx])
      begin
        found = 1'b1;
        win   = `BUS_ID_W'(idx);
      end
    end
  end

  // load still high means elink_tx has not shown busy yet
  always_ff @(posedge clk_40)
  begin
    if (!rst)
    begin
      grant <= '0;
      load  <= 1'b0;
      ptr   <= '0;
    end
    else
    begin
      grant <= '0;
      load  <= 1'b0;
      if (found && !busy && !load)
      begin
        grant <= `N_BUSES'(1) << win;
        load  <= 1'b1;
        ptr   <= `BUS_ID_W'((int'(win) + 1) % `N_BUSES);
      end
    end
  end

  always_ff @(posedge clk_40)
  begin
    if (found && !busy && !load)
      load_word <= up_word[win];
  end

endmodule

/* src/elink_tx.sv */
`include "mopshub_macros.svh"

module elink_tx (
  input  logic               clk_40,
  input  logic               rst,
  input  logic               load,
  input  logic [`ELINK_W-1:0] load_word,
  output logic               tx_elink,
  output logic               busy
);

  // Counts data bits plus the trailing idle bit
  localparam int CNT_W = $clog2(`ELINK_W + 2);

  logic [`ELINK_W-1:0] sh;
  logic [CNT_W-1:0]    cnt;

  always_ff @(posedge clk_40)
  begin
    if (!rst)
    begin
      tx_elink <= 1'b1;
      busy     <= 1'b0;
      cnt      <= '0;
    end
    else if (!busy)
    begin
      if (load)
      begin
        // Start bit
        tx_elink <= 1'b0;
        busy     <= 1'b1;
        cnt      <= '0;
      end
    end
    else
    begin
      cnt <= cnt + 1'b1;
      if (cnt < CNT_W'(`ELINK_W))
        tx_elink <= sh[`ELINK_W-1];
      else if (cnt == CNT_W'(`ELINK_W))
        tx_elink <= 1'b1;
      else
        busy <= 1'b0;
    end
  end

  // MSB first
  always_ff @(posedge clk_40)
  begin
    if (!busy && load)
      sh <= load_word;
    else if (busy)
      sh <= sh << 1;
  end

endmodule

/* src/elink_rx.sv */
`include "mopshub_macros.svh"

module elink_rx (
  input  logic                  clk_40,
  input  logic                  rst,
  input  logic                  rx_elink,
  output logic                  dn_valid,
  output logic [`BUS_ID_W-1:0]  dn_bus,
  output logic [`NODE_ID_W-1:0] dn_node,
  output logic [`PAYLOAD_W-1:0] dn_payload
);

  localparam logic [1:0] ST_IDLE  = 2'd0;
  localparam logic [1:0] ST_SHIFT = 2'd1;
  localparam logic [1:0] ST_WAIT  = 2'd2;
  localparam int         CNT_W    = $clog2(`ELINK_W);

  logic [1:0]          state;
  logic [CNT_W-1:0]    cnt;
  logic [`ELINK_W-2:0] sh;
  logic [`ELINK_W-1:0] word;
  logic                last_bit;

  assign word     = {sh, rx_elink};
  assign last_bit = state == ST_SHIFT && cnt == CNT_W'(`ELINK_W - 1);

  always_ff @(posedge clk_40)
  begin
    if (!rst)
    begin
      state    <= ST_IDLE;
      cnt      <= '0;
      dn_valid <= 1'b0;
    end
    else
    begin
      dn_valid <= 1'b0;
      case (state)
        ST_IDLE:
        begin
          if (!rx_elink)
          begin
            state <= ST_SHIFT;
            cnt   <= '0;
          end
        end
        ST_SHIFT:
        begin
          cnt <= cnt + 1'b1;
          if (last_bit)
          begin
            dn_valid <= 1'b1;
            state    <= ST_WAIT;
          end
        end
        // Hold off until the line is back high
        ST_WAIT:
        begin
          if (rx_elink)
            state <= ST_IDLE;
        end
        default:
          state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_40)
  begin
    if (state == ST_SHIFT)
      sh <= word[`ELINK_W-2:0];
  end

  always_ff @(posedge clk_40)
  begin
    if (last_bit)
    begin
      dn_bus     <= word[`ELINK_W-1 -: `BUS_ID_W];
      dn_node    <= word[`ELINK_W-`BUS_ID_W-1 -: `NODE_ID_W];
      dn_payload <= word[`ELINK_W-`BUS_ID_W-`NODE_ID_W-1 -: `PAYLOAD_W];
    end
  end

endmodule

/* src/mopshub_top.sv */
`include "mopshub_macros.svh"

module mopshub_top (
  input  logic                clk_40,
  input  logic                rst,
  input  logic [`N_BUSES-1:0] rx,
  input  logic                rx_elink,
  output logic [`N_BUSES-1:0] tx,
  output logic                tx_elink
);

  // Uplink
  logic [`N_BUSES-1:0]                  up_req;
  mopshub_pkg::hub_word_u [`N_BUSES-1:0] up_word;
  logic [`N_BUSES-1:0]                  grant;
  logic                                 load;
  mopshub_pkg::hub_word_u               load_word;
  logic                                 busy;

  // Downlink
  logic                  dn_valid;
  logic [`BUS_ID_W-1:0]  dn_bus;
  logic [`NODE_ID_W-1:0] dn_node;
  logic [`PAYLOAD_W-1:0] dn_payload;

  for (genvar i = 0; i < `N_BUSES; i++)
  begin : g_bus
    bus_channel #(
      .CH_ID (i)
    ) u_bus_channel (
      .clk_40     (clk_40),
      .rst        (rst),
      .rx         (rx[i]),
      .grant      (grant[i]),
      .dn_valid   (dn_valid),
      .dn_bus     (dn_bus),
      .dn_node    (dn_node),
      .dn_payload (dn_payload),
      .tx         (tx[i]),
      .up_req     (up_req[i]),
      .up_word    (up_word[i])
    );
  end

  uplink_arbiter u_uplink_arbiter (
    .clk_40    (clk_40),
    .rst       (rst),
    .up_req    (up_req),
    .up_word   (up_word),
    .busy      (busy),
    .grant     (grant),
    .load      (load),
    .load_word (load_word)
  );

  elink_tx u_elink_tx (
    .clk_40    (clk_40),
    .rst       (rst),
    .load      (load),
    .load_word (load_word),
    .tx_elink  (tx_elink),
    .busy      (busy)
  );

  elink_rx u_elink_rx (
    .clk_40     (clk_40),
    .rst        (rst),
    .rx_elink   (rx_elink),
    .dn_valid   (dn_valid),
    .dn_bus     (dn_bus),
    .dn_node    (dn_node),
    .dn_payload (dn_payload)
  );

endmodule

/* verif/tb_mopshub_top.sv */
`include "mopshub_macros.svh"

module tb_mopshub_top;

  // Rough cycle budget per test plus half again as margin
  localparam int FRAME_CYC = 27 * `MOPS_BIT_CYCLES;
  localparam int WORD_CYC  = `ELINK_W + 4;
  localparam int TEST_CYC  = 40 + 5 * (FRAME_CYC + WORD_CYC + 20)
                           + (2 * FRAME_CYC + 5 * WORD_CYC + 20)
                           + 4 * (WORD_CYC + FRAME_CYC + 20);
  localparam int MAX_CYC   = TEST_CYC * 3 / 2;

  logic                clk_40;
  logic                rst;
  logic [`N_BUSES-1:0] rx;
  logic                rx_elink;
  logic [`N_BUSES-1:0] tx;
  logic                tx_elink;

  int          cyc;
  int          errors;
  int          checks;
  int          seed;
  int          exp_ptr;
  int          last_start;
  int          frames_seen;
  int          stop_cyc [`N_BUSES];
  logic [7:0]  exp_err [`N_BUSES];
  logic [31:0] exp_up [$];
  logic [25:0] exp_dn [$];

  mopshub_top u_mopshub_top (
    .clk_40   (clk_40),
    .rst      (rst),
    .rx       (rx),
    .rx_elink (rx_elink),
    .tx       (tx),
    .tx_elink (tx_elink)
  );

  initial
  begin
    clk_40 = 1'b0;
    forever #20 clk_40 = ~clk_40;
  end

  // Cycle count and watchdog
  always @(posedge clk_40)
  begin
    cyc <= cyc + 1;
    if (cyc == MAX_CYC)
    begin
      $display("Timeout after %0d cycles, run stopped", cyc);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  // Grants go only to channels that still hold a request
  grant_to_requester: assert property (@(posedge clk_40) disable iff (!rst)
    (u_mopshub_top.grant & ~u_mopshub_top.up_req) == '0)
  else
  begin
    errors++;
    $display("Grant issued to a channel with no pending request");
  end

  // Line must idle high whenever the serializer is free
  elink_idle: assert property (@(posedge clk_40) disable iff (!rst)
    !u_mopshub_top.busy |-> tx_elink)
  else
  begin
    errors++;
    $display("tx_elink low while the e-link serializer is idle");
  end

  function automatic logic [31:0] make_data_word(input logic [1:0] bus,
                                                 input logic [7:0] node,
                                                 input logic [15:0] payload);
    return {1'b0, bus, node, payload, 5'b0};
  endfunction

  function automatic logic [31:0] make_status_word(input logic [1:0] bus,
                                                   input logic [7:0] cnt);
    return {1'b1, bus, cnt, 21'b0};
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got === exp)
    else
    begin
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic report_failure(input string msg);
    errors++;
    $display("%s", msg);
  endtask

  task automatic finish_test(input int num, input string name, input int err_before);
    $display("test %0d %s: %s", num, name, (errors == err_before) ? "ok" : "failed");
  endtask

  // Node on bus b sends one frame LSB first
  task automatic send_frame(input int b, input logic [7:0] node,
                            input logic [15:0] payload, input bit bad_parity);
    logic [26:0] bits;
    logic        par;
    par  = ^{node, payload} ^ bad_parity;
    bits = {1'b1, par, payload, node, 1'b0};
    for (int k = 0; k < 26; k++)
    begin
      rx[b] <= bits[k];
      repeat (`MOPS_BIT_CYCLES) @(posedge clk_40);
    end
    rx[b] <= 1'b1;
    repeat (`MOPS_BIT_CYCLES / 2) @(posedge clk_40);
    @(negedge clk_40);
    stop_cyc[b] = cyc;
    repeat (`MOPS_BIT_CYCLES / 2) @(posedge clk_40);
  endtask

  task automatic send_downlink(input logic [1:0] b, input logic [7:0] node,
                               input logic [15:0] payload);
    logic [31:0] w;
    w = {b, node, payload, 6'b0};
    rx_elink <= 1'b0;
    @(posedge clk_40);
    for (int i = 31; i >= 0; i--)
    begin
      rx_elink <= w[i];
      @(posedge clk_40);
    end
    rx_elink <= 1'b1;
    @(posedge clk_40);
  endtask

  task automatic wait_uplink();
    while (exp_up.size() != 0)
      @(posedge clk_40);
    repeat (4) @(posedge clk_40);
  endtask

  // E-link receiver model taking one bit per clock MSB first
  initial
  begin : elink_monitor
    logic [31:0] w;
    logic [31:0] exp;
    forever
    begin
      @(negedge clk_40);
      if (rst === 1'b1 && tx_elink === 1'b0)
      begin
        last_start = cyc;
        for (int i = 31; i >= 0; i--)
        begin
          @(negedge clk_40);
          w[i] = tx_elink;
        end
        if (exp_up.size() == 0)
          report_failure($sformatf("Uplink word %h arrived with none expected", w));
        else
        begin
          exp = exp_up.pop_front();
          check_value("tx_elink word", w, exp);
        end
      end
    end
  end

  // Decodes node frames on one tx line
  task automatic watch_bus(input int b);
    logic [26:0] bits;
    logic [25:0] exp;
    forever
    begin
      @(negedge clk_40);
      if (rst === 1'b1 && tx[b] === 1'b0)
      begin
        bits[0] = 1'b0;
        repeat (`MOPS_BIT_CYCLES / 2) @(negedge clk_40);
        for (int k = 1; k < 27; k++)
        begin
          repeat (`MOPS_BIT_CYCLES) @(negedge clk_40);
          bits[k] = tx[b];
        end
        frames_seen++;
        if (exp_dn.size() == 0)
          report_failure($sformatf("Node frame on tx[%0d] with none expected", b));
        else
        begin
          exp = exp_dn.pop_front();
          check_value("tx bus", b, exp[25:24]);
          check_value("tx node id", bits[8:1], exp[23:16]);
          check_value("tx payload", bits[24:9], exp[15:0]);
          check_value("tx parity", bits[25], ^exp[23:0]);
          check_value("tx stop bit", bits[26], 1'b1);
        end
      end
    end
  endtask

  initial watch_bus(0);
  initial watch_bus(1);
  initial watch_bus(2);
  initial watch_bus(3);

  initial
  begin : main
    logic [7:0]  nodes [`N_BUSES];
    logic [15:0] pays [`N_BUSES];
    logic [31:0] rnd;
    int          err0;
    int          b;
    int          last;
    seed        = 32'h413f67eb;
    cyc         = 0;
    errors      = 0;
    checks      = 0;
    exp_ptr     = 0;
    last_start  = 0;
    frames_seen = 0;
    for (int i = 0; i < `N_BUSES; i++)
      exp_err[i] = 8'd0;
    rst      = 1'b0;
    rx       = '1;
    rx_elink = 1'b1;
    repeat (8) @(posedge clk_40);
    rst <= 1'b1;

    // Quiet lines after reset
    err0 = errors;
    repeat (40)
    begin
      @(negedge clk_40);
      check_value("tx_elink", tx_elink, 1'b1);
      check_value("tx", tx, 4'hf);
    end
    finish_test(1, "idle after reset", err0);

    err0 = errors;
    for (b = 0; b < `N_BUSES; b++)
    begin
      rnd      = $random(seed);
      nodes[b] = rnd[7:0];
      pays[b]  = rnd[23:8];
      exp_up.push_back(make_data_word(b[1:0], nodes[b], pays[b]));
      @(posedge clk_40);
      send_frame(b, nodes[b], pays[b], 1'b0);
      wait_uplink();
      check_value("tx_elink start cycle", last_start, stop_cyc[b] + 2);
      exp_ptr = (b + 1) % `N_BUSES;
    end
    finish_test(2, "data word per bus", err0);

    // Bad parity on bus 1
    err0 = errors;
    rnd  = $random(seed);
    exp_err[1] = exp_err[1] + 8'd1;
    exp_up.push_back(make_status_word(2'd1, exp_err[1]));
    @(posedge clk_40);
    send_frame(1, rnd[7:0], rnd[23:8], 1'b1);
    wait_uplink();
    check_value("err_cnt bus 0", u_mopshub_top.g_bus[0].u_bus_channel.err_cnt, exp_err[0]);
    check_value("err_cnt bus 1", u_mopshub_top.g_bus[1].u_bus_channel.err_cnt, exp_err[1]);
    check_value("err_cnt bus 2", u_mopshub_top.g_bus[2].u_bus_channel.err_cnt, exp_err[2]);
    check_value("err_cnt bus 3", u_mopshub_top.g_bus[3].u_bus_channel.err_cnt, exp_err[3]);
    exp_ptr = 2;
    finish_test(3, "parity error status", err0);

    // Four at once and then an overrun on the last bus served
    err0 = errors;
    for (b = 0; b < `N_BUSES; b++)
    begin
      rnd      = $random(seed);
      nodes[b] = rnd[7:0];
      pays[b]  = rnd[23:8];
    end
    for (int k = 0; k < `N_BUSES; k++)
    begin
      b = (exp_ptr + k) % `N_BUSES;
      exp_up.push_back(make_data_word(b[1:0], nodes[b], pays[b]));
    end
    last = (exp_ptr + `N_BUSES - 1) % `N_BUSES;
    exp_err[last] = exp_err[last] + 8'd1;
    exp_up.push_back(make_status_word(last[1:0], exp_err[last]));
    @(posedge clk_40);
    fork
      send_frame(0, nodes[0], pays[0], 1'b0);
      send_frame(1, nodes[1], pays[1], 1'b0);
      send_frame(2, nodes[2], pays[2], 1'b0);
      send_frame(3, nodes[3], pays[3], 1'b0);
    join
    rnd = $random(seed);
    send_frame(last, rnd[7:0], rnd[23:8], 1'b0);
    wait_uplink();
    exp_ptr = (last + 1) % `N_BUSES;
    finish_test(4, "round robin and overrun", err0);

    err0 = errors;
    for (b = 0; b < `N_BUSES; b++)
    begin
      rnd  = $random(seed);
      exp_dn.push_back({b[1:0], rnd[7:0], rnd[23:8]});
      last = frames_seen;
      @(posedge clk_40);
      send_downlink(b[1:0], rnd[7:0], rnd[23:8]);
      while (frames_seen == last)
        @(posedge clk_40);
      repeat (4) @(posedge clk_40);
    end
    finish_test(5, "downlink commands", err0);

    repeat (20) @(posedge clk_40);
    if (exp_up.size() != 0 || exp_dn.size() != 0)
      report_failure("Expected words or frames never arrived");
    $display("tests 5, checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

endmodule

/* tb.f */
+incdir+include
src/mopshub_pkg.sv
src/bus_channel.sv
src/uplink_arbiter.sv
src/elink_tx.sv
src/elink_rx.sv
src/mopshub_top.sv
verif/tb_mopshub_top.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the hub testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_mopshub_top -f tb.f -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "ERRORS FOUND" sim.log; then
  exit 1
fi

exit 0
